// File: filelist.f
+incdir+hdl
hdl/fsab_pkg.sv
hdl/arb_pkg.sv
hdl/fsab_ring_fifo.sv
hdl/fsab_req_fifo.sv
hdl/fsab_arbiter.sv
hdl/fsab_arb_top.sv
bench/fsab_arb_tb.sv

// File: Makefile
# Verilator build and run for the two-port arbiter testbench.

VERILATOR  := verilator
TOP        := fsab_arb_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a crash or a missing line counts as failure.
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/fsab_arb_tb.sv
`timescale 1ns/1ps
`include "fsab_defines.svh"

// Testbench for the two-port arbiter.
// Two master models send random packets, a monitor keeps per-port scoreboards,
// and concurrent assertions compare every bus beat with the scoreboard heads.
module fsab_arb_tb;

	localparam int PKTS_PER_PORT   = 100;
	localparam int WATCHDOG_CYCLES = 2 * PKTS_PER_PORT * 20;

	// One expected bus beat, header fields repeated on every beat of a packet.
	typedef struct packed {
		fsab_pkg::mode_t         mode;
		logic [`FSAB_DID_W-1:0]  did;
		logic [`FSAB_DID_W-1:0]  subdid;
		logic [`FSAB_ADDR_W-1:0] addr;
		logic [`FSAB_LEN_W-1:0]  len;
		logic [`FSAB_DATA_W-1:0] data;
		logic [`FSAB_MASK_W-1:0] mask;
		logic                    first;
		logic                    last;
	} exp_beat_t;

	logic                    clk = 1'b0;
	logic                    Nrst;
	logic                    inp_valid_0, inp_valid_1;
	fsab_pkg::mode_t         inp_mode_0, inp_mode_1;
	logic [`FSAB_DID_W-1:0]  inp_did_0, inp_did_1;
	logic [`FSAB_DID_W-1:0]  inp_subdid_0, inp_subdid_1;
	logic [`FSAB_ADDR_W-1:0] inp_addr_0, inp_addr_1;
	logic [`FSAB_LEN_W-1:0]  inp_len_0, inp_len_1;
	logic [`FSAB_DATA_W-1:0] inp_data_0, inp_data_1;
	logic [`FSAB_MASK_W-1:0] inp_mask_0, inp_mask_1;
	logic                    inp_credit_0, inp_credit_1;
	logic                    bus_valid;
	arb_pkg::port_t          bus_port;
	fsab_pkg::mode_t         bus_mode;
	logic [`FSAB_DID_W-1:0]  bus_did;
	logic [`FSAB_DID_W-1:0]  bus_subdid;
	logic [`FSAB_ADDR_W-1:0] bus_addr;
	logic [`FSAB_LEN_W-1:0]  bus_len;
	logic [`FSAB_DATA_W-1:0] bus_data;
	logic [`FSAB_MASK_W-1:0] bus_mask;

	// Scoreboard queues, one per port, filled by the masters and drained by the monitor.
	exp_beat_t      sbq0 [$];
	exp_beat_t      sbq1 [$];
	exp_beat_t      exp_head [2];
	logic [1:0]     exp_ok;
	int             issued [2] = '{0, 0};
	int             stalls [2] = '{0, 0};
	int             returned [2];
	int             done [2];
	int             alt_checks;
	logic           sent_any = 1'b0;
	logic           mid_pkt;
	logic           alt_due;
	arb_pkg::port_t cur_port;
	arb_pkg::port_t last_pkt_port;

	fsab_arb_top fsab_arb_top_inst (
		.clk          (clk),          .Nrst         (Nrst),
		.inp_valid_0  (inp_valid_0),  .inp_valid_1  (inp_valid_1),
		.inp_mode_0   (inp_mode_0),   .inp_mode_1   (inp_mode_1),
		.inp_did_0    (inp_did_0),    .inp_did_1    (inp_did_1),
		.inp_subdid_0 (inp_subdid_0), .inp_subdid_1 (inp_subdid_1),
		.inp_addr_0   (inp_addr_0),   .inp_addr_1   (inp_addr_1),
		.inp_len_0    (inp_len_0),    .inp_len_1    (inp_len_1),
		.inp_data_0   (inp_data_0),   .inp_data_1   (inp_data_1),
		.inp_mask_0   (inp_mask_0),   .inp_mask_1   (inp_mask_1),
		.inp_credit_0 (inp_credit_0), .inp_credit_1 (inp_credit_1),
		.bus_valid    (bus_valid),    .bus_port     (bus_port),
		.bus_mode     (bus_mode),     .bus_did      (bus_did),
		.bus_subdid   (bus_subdid),   .bus_addr     (bus_addr),
		.bus_len      (bus_len),      .bus_data     (bus_data),
		.bus_mask     (bus_mask)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// Prints the reason, then the fail message, and stops the run.
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Run stopped at the first error.");
	endtask

	// 32-bit xorshift step.
	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Puts one beat on the inbound port p.
	task automatic drive_port(input int p, input logic valid, input exp_beat_t b);
		if (p == 0) begin
			inp_valid_0  = valid;
			inp_mode_0   = b.mode;
			inp_did_0    = b.did;
			inp_subdid_0 = b.subdid;
			inp_addr_0   = b.addr;
			inp_len_0    = b.len;
			inp_data_0   = b.data;
			inp_mask_0   = b.mask;
		end else begin
			inp_valid_1  = valid;
			inp_mode_1   = b.mode;
			inp_did_1    = b.did;
			inp_subdid_1 = b.subdid;
			inp_addr_1   = b.addr;
			inp_len_1    = b.len;
			inp_data_1   = b.data;
			inp_mask_1   = b.mask;
		end
	endtask

	// Master model for port p.
	// It spends one credit per packet and waits while none is left.
	task automatic run_master(input int p, input logic [31:0] seed);
		logic [31:0] rs;
		exp_beat_t   b;
		int          beats;
		int          gap;
		rs = seed;
		b = '0;
		for (int n = 0; n < PKTS_PER_PORT; n++) begin
			if (issued[p] - returned[p] >= `FSAB_CREDITS) begin
				stalls[p]++;
				drive_port(p, 1'b0, '0);
				while (issued[p] - returned[p] >= `FSAB_CREDITS)
					@(negedge clk);
			end
			rs = next_rand(rs);
			if (rs[0]) begin
				b.mode = fsab_pkg::FSAB_WRITE;
				b.len  = `FSAB_LEN_W'(rs[2:1]) + `FSAB_LEN_W'(1);
			end else begin
				b.mode = fsab_pkg::FSAB_READ;
				b.len  = `FSAB_LEN_W'(1);
			end
			b.did    = rs[7:4];
			b.subdid = rs[11:8];
			rs = next_rand(rs);
			b.addr = rs[`FSAB_ADDR_W-1:0];
			beats = (b.mode == fsab_pkg::FSAB_WRITE) ? int'(b.len) : 1;
			for (int k = 0; k < beats; k++) begin
				rs = next_rand(rs);
				b.data[63:32] = rs;
				rs = next_rand(rs);
				b.data[31:0] = rs;
				b.mask  = rs[15:8];
				b.first = (k == 0);
				b.last  = (k == beats - 1);
				if (p == 0)
					sbq0.push_back(b);
				else
					sbq1.push_back(b);
				if (k == 0) begin
					issued[p]++;
					sent_any = 1'b1;
				end
				drive_port(p, 1'b1, b);
				@(negedge clk);
			end
			// Mostly back to back, with a short pause now and then.
			rs = next_rand(rs);
			gap = (rs[2:0] == 3'd0) ? int'(rs[4:3]) + 1 : 0;
			if (gap > 0) begin
				drive_port(p, 1'b0, '0);
				repeat (gap) @(negedge clk);
			end
		end
		drive_port(p, 1'b0, '0);
	endtask

	// Bus monitor.
	// It pops the beat just seen and loads the next heads for the assertions at the next edge.
	always @(posedge clk) begin
		exp_beat_t head;
		if (!Nrst) begin
			returned      <= '{0, 0};
			done          <= '{0, 0};
			alt_checks    <= 0;
			mid_pkt       <= 1'b0;
			alt_due       <= 1'b0;
			cur_port      <= '0;
			last_pkt_port <= '0;
		end else begin
			if (inp_credit_0)
				returned[0] <= returned[0] + 1;
			if (inp_credit_1)
				returned[1] <= returned[1] + 1;
			if (bus_valid) begin
				head = '0;
				if (bus_port == 1'b0 && sbq0.size() > 0)
					head = sbq0.pop_front();
				else if (bus_port == 1'b1 && sbq1.size() > 0)
					head = sbq1.pop_front();
				mid_pkt  <= !head.last;
				cur_port <= bus_port;
				if (head.last)
					done[bus_port] <= done[bus_port] + 1;
				if (head.first) begin
					if (alt_due)
						alt_checks <= alt_checks + 1;
					// The other port already waits, so the next packet must be its.
					alt_due <= (bus_port == 1'b0) ? (sbq1.size() > 0) : (sbq0.size() > 0);
					last_pkt_port <= bus_port;
				end
			end
		end
		exp_ok[0]   <= (sbq0.size() > 0);
		exp_ok[1]   <= (sbq1.size() > 0);
		exp_head[0] <= (sbq0.size() > 0) ? sbq0[0] : '0;
		exp_head[1] <= (sbq1.size() > 0) ? sbq1[0] : '0;
	end

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (!Nrst)
		!sent_any |-> (!bus_valid && !inp_credit_0 && !inp_credit_1))
		else abort_run($sformatf("ERR %0t: bus or credit activity before any packet", $time));

	a_beat_expected: assert property (@(posedge clk) disable iff (!Nrst)
		bus_valid |-> exp_ok[bus_port])
		else abort_run($sformatf("ERR %0t: unexpected beat on port %0d", $time, bus_port));

	a_header_match: assert property (@(posedge clk) disable iff (!Nrst)
		bus_valid |-> (bus_mode == exp_head[bus_port].mode &&
			bus_did == exp_head[bus_port].did &&
			bus_subdid == exp_head[bus_port].subdid &&
			bus_addr == exp_head[bus_port].addr &&
			bus_len == exp_head[bus_port].len))
		else abort_run($sformatf(
			"ERR %0t: header on port %0d is addr %h len %0d, expected %h %0d",
			$time, bus_port, bus_addr, bus_len, exp_head[bus_port].addr,
			exp_head[bus_port].len));

	// Read data is don't-care on the bus, so only write beats are compared.
	a_write_data: assert property (@(posedge clk) disable iff (!Nrst)
		(bus_valid && exp_head[bus_port].mode == fsab_pkg::FSAB_WRITE) |->
		(bus_data == exp_head[bus_port].data && bus_mask == exp_head[bus_port].mask))
		else abort_run($sformatf("ERR %0t: data %h mask %h, expected %h %h", $time, bus_data,
			bus_mask, exp_head[bus_port].data, exp_head[bus_port].mask));

	a_no_interleave: assert property (@(posedge clk) disable iff (!Nrst)
		(bus_valid && mid_pkt) |-> (bus_port == cur_port))
		else abort_run($sformatf("ERR %0t: port %0d cut into a packet of port %0d", $time,
			bus_port, cur_port));

	a_packet_start: assert property (@(posedge clk) disable iff (!Nrst)
		(bus_valid && !mid_pkt) |-> exp_head[bus_port].first)
		else abort_run($sformatf("ERR %0t: packet on port %0d starts mid-packet", $time,
			bus_port));

	a_round_robin: assert property (@(posedge clk) disable iff (!Nrst)
		(bus_valid && !mid_pkt && alt_due) |-> (bus_port != last_pkt_port))
		else abort_run($sformatf("ERR %0t: port %0d served twice while the other waited", $time,
			bus_port));

	// Credits come back only for packets that have left.
	a_credit_count: assert property (@(posedge clk) disable iff (!Nrst)
		(returned[0] <= done[0]) && (returned[1] <= done[1]))
		else abort_run($sformatf("ERR %0t: credits returned %0d/%0d for packets done %0d/%0d",
			$time, returned[0], returned[1], done[0], done[1]));

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		logic final_ok;
		Nrst = 1'b0;
		drive_port(0, 1'b0, '0);
		drive_port(1, 1'b0, '0);
		repeat (10) @(negedge clk);
		Nrst = 1'b1;
		@(negedge clk);
		fork
			run_master(0, 32'd15157);
			run_master(1, 32'd15157 ^ 32'h9e3779b9);
		join
		// Let the buffers drain and hand back every credit.
		while (!(sbq0.size() == 0 && sbq1.size() == 0 &&
			returned[0] == issued[0] && returned[1] == issued[1]))
			@(negedge clk);
		repeat (5) @(negedge clk);
		final_ok = (done[0] == PKTS_PER_PORT) && (done[1] == PKTS_PER_PORT) &&
			(returned[0] == done[0]) && (returned[1] == done[1]) &&
			(stalls[0] > 0) && (stalls[1] > 0) && (alt_checks > 0);
		if (final_ok) begin
			$display("All tests passed");
			$finish;
		end else begin
			abort_run($sformatf("Wrong end counts: done %0d/%0d, stalls %0d/%0d, alternations %0d",
				done[0], done[1], stalls[0], stalls[1], alt_checks));
		end
	end

endmodule

// File: hdl/fsab_arb_top.sv
`timescale 1ns/1ps
`include "fsab_defines.svh"

// Two-master front end for the shared memory bus.
// Each master feeds its own credit buffer, and the arbiter merges both onto one bus.
module fsab_arb_top (
	input  logic                    clk,
	input  logic                    Nrst,

	input  logic                    inp_valid_0,  inp_valid_1,
	input  fsab_pkg::mode_t         inp_mode_0,   inp_mode_1,
	input  logic [`FSAB_DID_W-1:0]  inp_did_0,    inp_did_1,
	input  logic [`FSAB_DID_W-1:0]  inp_subdid_0, inp_subdid_1,
	input  logic [`FSAB_ADDR_W-1:0] inp_addr_0,   inp_addr_1,
	input  logic [`FSAB_LEN_W-1:0]  inp_len_0,    inp_len_1,
	input  logic [`FSAB_DATA_W-1:0] inp_data_0,   inp_data_1,
	input  logic [`FSAB_MASK_W-1:0] inp_mask_0,   inp_mask_1,
	output logic                    inp_credit_0, inp_credit_1,

	output logic                    bus_valid,
	output arb_pkg::port_t          bus_port,
	output fsab_pkg::mode_t         bus_mode,
	output logic [`FSAB_DID_W-1:0]  bus_did,
	output logic [`FSAB_DID_W-1:0]  bus_subdid,
	output logic [`FSAB_ADDR_W-1:0] bus_addr,
	output logic [`FSAB_LEN_W-1:0]  bus_len,
	output logic [`FSAB_DATA_W-1:0] bus_data,
	output logic [`FSAB_MASK_W-1:0] bus_mask
);

	// Buffer-to-arbiter wiring, indexed by port.
	logic [`FSAB_PORTS-1:0]  empty_b;
	logic [`FSAB_PORTS-1:0]  active;
	logic [`FSAB_PORTS-1:0]  start_trans;
	logic [`FSAB_PORTS-1:0]  src_valid;
	fsab_pkg::mode_t         src_mode   [`FSAB_PORTS];
	logic [`FSAB_DID_W-1:0]  src_did    [`FSAB_PORTS];
	logic [`FSAB_DID_W-1:0]  src_subdid [`FSAB_PORTS];
	logic [`FSAB_ADDR_W-1:0] src_addr   [`FSAB_PORTS];
	logic [`FSAB_LEN_W-1:0]  src_len    [`FSAB_PORTS];
	logic [`FSAB_DATA_W-1:0] src_data   [`FSAB_PORTS];
	logic [`FSAB_MASK_W-1:0] src_mask   [`FSAB_PORTS];

	fsab_req_fifo req_fifo_0 (
		.clk        (clk),               .Nrst       (Nrst),
		.inp_valid  (inp_valid_0),       .inp_mode   (inp_mode_0),
		.inp_did    (inp_did_0),         .inp_subdid (inp_subdid_0),
		.inp_addr   (inp_addr_0),        .inp_len    (inp_len_0),
		.inp_data   (inp_data_0),        .inp_mask   (inp_mask_0),
		.inp_credit (inp_credit_0),      .start_trans(start_trans[0]),
		.empty_b    (empty_b[0]),        .active     (active[0]),
		.out_valid  (src_valid[0]),      .out_mode   (src_mode[0]),
		.out_did    (src_did[0]),        .out_subdid (src_subdid[0]),
		.out_addr   (src_addr[0]),       .out_len    (src_len[0]),
		.out_data   (src_data[0]),       .out_mask   (src_mask[0])
	);

	fsab_req_fifo req_fifo_1 (
		.clk        (clk),               .Nrst       (Nrst),
		.inp_valid  (inp_valid_1),       .inp_mode   (inp_mode_1),
		.inp_did    (inp_did_1),         .inp_subdid (inp_subdid_1),
		.inp_addr   (inp_addr_1),        .inp_len    (inp_len_1),
		.inp_data   (inp_data_1),        .inp_mask   (inp_mask_1),
		.inp_credit (inp_credit_1),      .start_trans(start_trans[1]),
		.empty_b    (empty_b[1]),        .active     (active[1]),
		.out_valid  (src_valid[1]),      .out_mode   (src_mode[1]),
		.out_did    (src_did[1]),        .out_subdid (src_subdid[1]),
		.out_addr   (src_addr[1]),       .out_len    (src_len[1]),
		.out_data   (src_data[1]),       .out_mask   (src_mask[1])
	);

	// The grant also leaves on bus_port, so the separate grant output stays open here.
	fsab_arbiter arbiter (
		.clk        (clk),               .Nrst       (Nrst),
		.empty_b    (empty_b),           .active     (active),
		.start_trans(start_trans),       .grant      (),
		.src_valid  (src_valid),         .src_mode   (src_mode),
		.src_did    (src_did),           .src_subdid (src_subdid),
		.src_addr   (src_addr),          .src_len    (src_len),
		.src_data   (src_data),          .src_mask   (src_mask),
		.bus_valid  (bus_valid),         .bus_port   (bus_port),
		.bus_mode   (bus_mode),          .bus_did    (bus_did),
		.bus_subdid (bus_subdid),        .bus_addr   (bus_addr),
		.bus_len    (bus_len),           .bus_data   (bus_data),
		.bus_mask   (bus_mask)
	);

endmodule

// File: hdl/fsab_arbiter.sv
`timescale 1ns/1ps
`include "fsab_defines.svh"

// Round-robin arbiter in front of the shared bus.
// It grants one buffer at a time and steers that buffer's replay onto the bus.
module fsab_arbiter (
	input  logic                    clk,
	input  logic                    Nrst,

	input  logic [`FSAB_PORTS-1:0]  empty_b,
	input  logic [`FSAB_PORTS-1:0]  active,
	output logic [`FSAB_PORTS-1:0]  start_trans,
	output arb_pkg::port_t          grant,

	input  logic [`FSAB_PORTS-1:0]  src_valid,
	input  fsab_pkg::mode_t         src_mode   [`FSAB_PORTS],
	input  logic [`FSAB_DID_W-1:0]  src_did    [`FSAB_PORTS],
	input  logic [`FSAB_DID_W-1:0]  src_subdid [`FSAB_PORTS],
	input  logic [`FSAB_ADDR_W-1:0] src_addr   [`FSAB_PORTS],
	input  logic [`FSAB_LEN_W-1:0]  src_len    [`FSAB_PORTS],
	input  logic [`FSAB_DATA_W-1:0] src_data   [`FSAB_PORTS],
	input  logic [`FSAB_MASK_W-1:0] src_mask   [`FSAB_PORTS],

	output logic                    bus_valid,
	output arb_pkg::port_t          bus_port,
	output fsab_pkg::mode_t         bus_mode,
	output logic [`FSAB_DID_W-1:0]  bus_did,
	output logic [`FSAB_DID_W-1:0]  bus_subdid,
	output logic [`FSAB_ADDR_W-1:0] bus_addr,
	output logic [`FSAB_LEN_W-1:0]  bus_len,
	output logic [`FSAB_DATA_W-1:0] bus_data,
	output logic [`FSAB_MASK_W-1:0] bus_mask
);

	arb_pkg::grant_state_t         state;
	arb_pkg::port_t                last;
	arb_pkg::port_t                next_grant;
	logic                          found;
	logic [`FSAB_PORTS-1:0]        req;
	logic [`FSAB_PORTS-1:0]        grant_oh;

	// A port competes only when it holds a header and is not still draining.
	assign req = empty_b & ~active;

	// Search starts at the port after the last one served, which gives the rotation.
	always_comb begin
		int idx;
		found      = 1'b0;
		next_grant = last;
		for (int i = 1; i <= `FSAB_PORTS; i++) begin
			idx = (int'(last) + i) % `FSAB_PORTS;
			if (!found && req[idx]) begin
				found      = 1'b1;
				next_grant = arb_pkg::port_t'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			state <= arb_pkg::ARB_IDLE;
			grant <= '0;
			// Port zero goes first after reset.
			last  <= arb_pkg::port_t'(`FSAB_PORTS - 1);
		end else begin
			case (state)
				arb_pkg::ARB_IDLE: begin
					if (found) begin
						grant <= next_grant;
						state <= arb_pkg::ARB_START;
					end
				end
				arb_pkg::ARB_START: begin
					state <= arb_pkg::ARB_BUSY;
				end
				arb_pkg::ARB_BUSY: begin
					// The granted buffer raises active on the cycle after start_trans.
					// Its fall means the whole packet has left.
					if (!active[grant]) begin
						last  <= grant;
						state <= arb_pkg::ARB_IDLE;
					end
				end
				default: begin
					state <= arb_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	assign grant_oh = `FSAB_PORTS'(1) << grant;

	// The replay strobe lasts exactly the one START cycle.
	assign start_trans = (state == arb_pkg::ARB_START) ? grant_oh : '0;

	// The bus follows the granted buffer with no register in between.
	assign bus_valid  = src_valid[grant];
	assign bus_port   = grant;
	assign bus_mode   = src_mode[grant];
	assign bus_did    = src_did[grant];
	assign bus_subdid = src_subdid[grant];
	assign bus_addr   = src_addr[grant];
	assign bus_len    = src_len[grant];
	assign bus_data   = src_data[grant];
	assign bus_mask   = src_mask[grant];

	// The winner was picked a cycle earlier, so its request must still stand at the strobe.
	a_start_to_ready: assert property (@(posedge clk) disable iff (!Nrst)
		(start_trans & ~req) == '0)
		else $error("fsab_arbiter: start_trans to a port that is not ready");

	// A buffer only replays while it holds the grant and the FSM is waiting on it.
	// Any other beat would be dropped by the multiplexer.
	a_valid_from_grant: assert property (@(posedge clk) disable iff (!Nrst)
		(src_valid != '0) |->
		((state == arb_pkg::ARB_BUSY) && ((src_valid & ~grant_oh) == '0)))
		else $error("fsab_arbiter: beat from a port without the grant");

endmodule

// File: hdl/fsab_req_fifo.sv
`timescale 1ns/1ps
`include "fsab_defines.svh"

// Credit-managed request buffer for one bus master.
// Inbound packets are split into a header FIFO and a data FIFO.
// A start_trans strobe replays the oldest packet on the out_* fields.
// A credit goes back to the master once the packet has fully left.
module fsab_req_fifo (
	input  logic                    clk,
	input  logic                    Nrst,

	input  logic                    inp_valid,
	input  fsab_pkg::mode_t         inp_mode,
	input  logic [`FSAB_DID_W-1:0]  inp_did,
	input  logic [`FSAB_DID_W-1:0]  inp_subdid,
	input  logic [`FSAB_ADDR_W-1:0] inp_addr,
	input  logic [`FSAB_LEN_W-1:0]  inp_len,
	input  logic [`FSAB_DATA_W-1:0] inp_data,
	input  logic [`FSAB_MASK_W-1:0] inp_mask,
	output logic                    inp_credit,

	input  logic                    start_trans,
	output logic                    empty_b,
	output logic                    active,

	output logic                    out_valid,
	output fsab_pkg::mode_t         out_mode,
	output logic [`FSAB_DID_W-1:0]  out_did,
	output logic [`FSAB_DID_W-1:0]  out_subdid,
	output logic [`FSAB_ADDR_W-1:0] out_addr,
	output logic [`FSAB_LEN_W-1:0]  out_len,
	output logic [`FSAB_DATA_W-1:0] out_data,
	output logic [`FSAB_MASK_W-1:0] out_mask
);

	fsab_pkg::hdr_t         hdr_wdata;
	fsab_pkg::hdr_t         hdr_rdata;
	fsab_pkg::beat_t        dat_wdata;
	fsab_pkg::beat_t        dat_rdata;
	logic                   hdr_wr;
	logic                   hdr_rd;
	logic                   hdr_empty;
	logic                   dat_rd;
	logic [`FSAB_LEN_W-1:0] in_rem;
	logic                   in_done;
	logic                   hdr_rd_q;
	logic                   dat_rd_q;
	logic                   cur_active;
	logic                   cur_active_q;
	logic [`FSAB_LEN_W-1:0] cur_rem;

	// Beats still owed by the inbound write that is in progress.
	// A value of one means the previous beat was the last one, so this beat opens a packet.
	assign in_done = (in_rem == '0) || (in_rem == `FSAB_LEN_W'(1));

	// Only the opening beat of a packet carries a header.
	assign hdr_wr = inp_valid && in_done;
	assign hdr_wdata = '{
		mode:   inp_mode,
		did:    inp_did,
		subdid: inp_subdid,
		addr:   inp_addr,
		len:    inp_len
	};

	// Every valid beat lands in the data FIFO, reads included.
	// That keeps the two FIFOs in step, because a replay always pops one of each.
	assign dat_wdata = '{data: inp_data, mask: inp_mask};

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			in_rem <= '0;
		end else if (inp_valid && in_done && (inp_mode == fsab_pkg::FSAB_WRITE)) begin
			in_rem <= inp_len;
		end else if (inp_valid && (in_rem != '0)) begin
			in_rem <= in_rem - 1'b1;
		end
	end

	fsab_ring_fifo #(
		.payload_t (fsab_pkg::hdr_t),
		.DEPTH     (`FSAB_CREDITS)
	) hdr_fifo (
		.clk   (clk),
		.Nrst  (Nrst),
		.wr    (hdr_wr),
		.wdata (hdr_wdata),
		.rd    (hdr_rd),
		.rdata (hdr_rdata),
		.empty (hdr_empty),
		.full  ()
	);

	fsab_ring_fifo #(
		.payload_t (fsab_pkg::beat_t),
		.DEPTH     (`FSAB_CREDITS * `FSAB_LEN_MAX)
	) dat_fifo (
		.clk   (clk),
		.Nrst  (Nrst),
		.wr    (inp_valid),
		.wdata (dat_wdata),
		.rd    (dat_rd),
		.rdata (dat_rdata),
		.empty (),
		.full  ()
	);

	// A stored header is enough to ask for the bus.
	// The rest of a write may still be arriving, which the one idle beat in the replay absorbs.
	assign empty_b = !hdr_empty;

	// The header is popped on the start_trans cycle.
	// The data FIFO is popped on the same cycle, so its first beat pairs with the header.
	assign hdr_rd = start_trans && !hdr_empty && !cur_active && !hdr_rd_q;

	// Once the header length is loaded, a write keeps pulling beats until one remains.
	// That last count stands for the beat that went out with the header.
	assign dat_rd = hdr_rd ||
		(cur_active && (hdr_rdata.mode == fsab_pkg::FSAB_WRITE) &&
		 (cur_rem != `FSAB_LEN_W'(1)) && (cur_rem != '0));

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			hdr_rd_q     <= 1'b0;
			dat_rd_q     <= 1'b0;
			cur_active   <= 1'b0;
			cur_active_q <= 1'b0;
			cur_rem      <= '0;
		end else begin
			hdr_rd_q     <= hdr_rd;
			dat_rd_q     <= dat_rd;
			cur_active_q <= cur_active;
			// The header is visible one cycle after its read.
			// Only writes need a drain phase.
			if (hdr_rd_q && (hdr_rdata.mode == fsab_pkg::FSAB_WRITE)) begin
				cur_active <= 1'b1;
				cur_rem    <= hdr_rdata.len;
			end else if (cur_active && dat_rd) begin
				cur_rem <= cur_rem - 1'b1;
			end else if (cur_active) begin
				cur_active <= 1'b0;
			end
		end
	end

	// The buffer stays busy from the header pop until the drain has settled.
	assign active = hdr_rd_q || cur_active || cur_active_q;

	// A write hands back its credit when the drain phase ends.
	// A read has nothing to drain and returns it as soon as its header is seen.
	assign inp_credit = (cur_active_q && !cur_active) ||
		(hdr_rd_q && (hdr_rdata.mode == fsab_pkg::FSAB_READ));

	// Each popped data beat shows up on the outbound fields one cycle later.
	assign out_valid  = dat_rd_q;
	assign out_mode   = hdr_rdata.mode;
	assign out_did    = hdr_rdata.did;
	assign out_subdid = hdr_rdata.subdid;
	assign out_addr   = hdr_rdata.addr;
	assign out_len    = hdr_rdata.len;
	assign out_data   = dat_rdata.data;
	assign out_mask   = dat_rdata.mask;

	// The arbiter may only start a replay on an idle buffer.
	a_start_when_idle: assert property (@(posedge clk) disable iff (!Nrst)
		start_trans |-> !active)
		else $error("fsab_req_fifo: start_trans while active");

endmodule

// File: hdl/fsab_ring_fifo.sv
`timescale 1ns/1ps

// Ring buffer over a power-of-two array.
// Each pointer carries one extra wrap bit so that full and empty can be told apart.
module fsab_ring_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     Nrst,
	input  logic     wr,
	input  payload_t wdata,
	input  logic     rd,
	output payload_t rdata,
	output logic     empty,
	output logic     full
);

	localparam int AW = $clog2(DEPTH);

	payload_t    mem [DEPTH];
	logic [AW:0] wptr;
	logic [AW:0] rptr;

	// The FIFO is empty when both pointers match, wrap bit included.
	assign empty = (wptr == rptr);

	// It is full when the index bits match but the writer has wrapped once more.
	assign full = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (wr)
				wptr <= wptr + 1'b1;
			if (rd)
				rptr <= rptr + 1'b1;
		end
	end

	// The storage array and the read register.
	// A read strobe in one cycle makes the entry visible on rdata in the next.
	// rdata holds its value between reads, which the replay logic relies on.
	always_ff @(posedge clk) begin
		if (wr)
			mem[wptr[AW-1:0]] <= wdata;
		if (rd)
			rdata <= mem[rptr[AW-1:0]];
	end

	// The credit scheme upstream must keep the writer from overrunning the ring.
	a_no_write_when_full: assert property (@(posedge clk) disable iff (!Nrst)
		!(wr && full && !rd))
		else $error("fsab_ring_fifo: write while full");

	// The replay control must never run ahead of the data that has arrived.
	a_no_read_when_empty: assert property (@(posedge clk) disable iff (!Nrst)
		!(rd && empty))
		else $error("fsab_ring_fifo: read while empty");

endmodule

// File: hdl/arb_pkg.sv
`include "fsab_defines.svh"

// Types private to the arbitration logic.
package arb_pkg;

	// Index of one arbitrated port.
	// It also serves as the tag that rides on the outbound bus.
	typedef logic [$clog2(`FSAB_PORTS)-1:0] port_t;

	// Grant FSM states.
	// IDLE picks a winner, START issues the replay strobe, and BUSY waits for the drain.
	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_START = 2'd1,
		ARB_BUSY  = 2'd2
	} grant_state_t;

endpackage

// File: hdl/fsab_pkg.sv
`include "fsab_defines.svh"

// Types that describe a request as it appears on the shared memory bus.
package fsab_pkg;

	// Request kind.
	// A read carries one beat whose data is ignored, and a write carries len beats.
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} mode_t;

	// Everything a request says about itself, captured once on its first beat.
	// The header FIFO stores one of these per packet.
	typedef struct packed {
		mode_t                   mode;
		logic [`FSAB_DID_W-1:0]  did;
		logic [`FSAB_DID_W-1:0]  subdid;
		logic [`FSAB_ADDR_W-1:0] addr;
		logic [`FSAB_LEN_W-1:0]  len;
	} hdr_t;

	// One data beat with its byte enables.
	// The data FIFO stores one of these for every inbound valid cycle.
	typedef struct packed {
		logic [`FSAB_DATA_W-1:0] data;
		logic [`FSAB_MASK_W-1:0] mask;
	} beat_t;

endpackage

// File: hdl/fsab_defines.svh
`ifndef FSAB_DEFINES_SVH
`define FSAB_DEFINES_SVH

// Field widths of the shared memory bus.
// The address counts 64-bit words, so 30 bits cover an 8 GiB space.
`define FSAB_ADDR_W 30
`define FSAB_DATA_W 64

// One mask bit per data byte.
`define FSAB_MASK_W 8

// Length in beats; it must be able to hold FSAB_LEN_MAX itself.
`define FSAB_LEN_W 3

// Device and sub-device identifiers travel with every request.
`define FSAB_DID_W 4

// Credits handed to each master at reset.
// The header FIFO holds exactly this many packets, so a master can never overrun it.
`define FSAB_CREDITS 4

// Longest write burst, in beats.
// Together with the credit count it sizes the data FIFO.
`define FSAB_LEN_MAX 4

// Number of masters that share the bus.
`define FSAB_PORTS 2

`endif
